// ==== src/fpu_pkg.sv ====
package fpu_pkg;

    // ieee single and its fields
    typedef logic [31:0] float_t;
    typedef logic [7:0]  exp_t;
    typedef logic [22:0] mant_t;

    typedef logic [2:0] op_t;
    typedef logic [1:0] cmp_t;

    // codes 5 to 7 fall back to fadd
    localparam op_t OP_FADD = 3'd0;
    localparam op_t OP_FSUB = 3'd1;
    localparam op_t OP_FEQ  = 3'd2;
    localparam op_t OP_FLT  = 3'd3;
    localparam op_t OP_FLE  = 3'd4;

    // compare kind, decode to result
    localparam cmp_t CMP_EQ = 2'd0;
    localparam cmp_t CMP_LT = 2'd1;
    localparam cmp_t CMP_LE = 2'd2;

endpackage

// ==== src/lzc.sv ====
`timescale 1ns/100ps

module lzc (
    input  logic [24:0] x,
    output logic [4:0]  res
);

    // highest set bit wins, zero input counts 24
    always_comb begin
        res = 5'd24;
        for (int i = 0; i < 25; i++) begin
            if (x[i]) begin
                res = 5'(24 - i);
            end
        end
    end

endmodule

// ==== src/fadd.sv ====
`timescale 1ns/100ps

module fadd (
    input  fpu_pkg::float_t x,
    input  fpu_pkg::float_t y,
    output fpu_pkg::float_t res
);

    logic           sx;
    logic           sy;
    fpu_pkg::exp_t  ex;
    fpu_pkg::exp_t  ey;
    fpu_pkg::mant_t mx;
    fpu_pkg::mant_t my;
    logic [8:0]     exy;
    logic [8:0]     eyx;
    logic           x_bigger;
    fpu_pkg::exp_t  eb;
    fpu_pkg::exp_t  es;
    logic [7:0]     ediff;
    fpu_pkg::mant_t mb;
    fpu_pkg::mant_t ms;
    logic [23:0]    mb_sup;
    logic [23:0]    ms_sup;
    logic           s_big;
    logic           is_add;
    logic           is_close;
    logic [49:0]    ms_ext;
    logic [49:0]    ms_shifted;
    logic [26:0]    ms_packed;
    logic [27:0]    mb_ext;
    logic [27:0]    m_far;
    logic           udf_f;
    logic           ovf_f;
    logic           s_far;
    fpu_pkg::exp_t  e_far;
    logic [24:0]    m_far_n;
    logic           st_far;
    logic [24:0]    ms_c;
    logic [25:0]    mb_c;
    logic [25:0]    d_bs;
    logic [25:0]    d_sb;
    logic [24:0]    m_abs;
    logic           s_close;
    logic [4:0]     lz;
    logic [8:0]     e_norm;
    logic           udf_c;
    logic [24:0]    m_close;
    fpu_pkg::exp_t  e_close;
    logic           s_pre;
    fpu_pkg::exp_t  e_pre;
    logic [24:0]    m_pre;
    logic           st_pre;
    logic           round_up;
    logic [24:0]    m_rnd;

    assign {sx, ex, mx} = x;
    assign {sy, ey, my} = y;

    // order operands by exponent
    assign exy      = {1'b0, ex} - {1'b0, ey};
    assign eyx      = {1'b0, ey} - {1'b0, ex};
    assign x_bigger = ~exy[8];
    assign eb       = x_bigger ? ex : ey;
    assign es       = x_bigger ? ey : ex;
    assign ediff    = x_bigger ? exy[7:0] : eyx[7:0];
    assign mb       = x_bigger ? mx : my;
    assign ms       = x_bigger ? my : mx;
    // zero exponent reads as zero
    assign mb_sup   = (eb != 8'd0) ? {1'b1, mb} : 24'd0;
    assign ms_sup   = (es != 8'd0) ? {1'b1, ms} : 24'd0;
    assign s_big    = x_bigger ? sx : sy;
    assign is_add   = ~(sx ^ sy);
    assign is_close = (ediff[7:1] == 7'd0) & ~is_add;

    // far path: align with two guard bits and sticky
    assign ms_ext     = {ms_sup, 26'd0};
    assign ms_shifted = (ediff >= 8'd26) ? {26'd0, ms_sup} : ms_ext >> ediff;
    assign ms_packed  = {ms_shifted[49:24], |ms_shifted[23:0]};
    assign mb_ext     = {1'b0, mb_sup, 3'd0};
    assign m_far      = is_add ? mb_ext + {1'b0, ms_packed} : mb_ext - {1'b0, ms_packed};

    assign udf_f = (eb == 8'd0) | ((eb == 8'd1) & ~m_far[27] & ~m_far[26]);
    assign ovf_f = (eb == 8'd255) | ((eb == 8'd254) & m_far[27]);
    assign s_far = udf_f ? 1'b0 : s_big;

    // at most one bit of normalize either way
    always_comb begin
        if (m_far[27]) begin
            e_far   = eb + 8'd1;
            m_far_n = m_far[27:3];
            st_far  = |m_far[2:0];
        end else if (m_far[26]) begin
            e_far   = eb;
            m_far_n = m_far[26:2];
            st_far  = |m_far[1:0];
        end else begin
            e_far   = eb - 8'd1;
            m_far_n = m_far[25:1];
            st_far  = m_far[0];
        end
        if (udf_f) begin
            e_far   = 8'd0;
            m_far_n = 25'd0;
        end else if (ovf_f) begin
            e_far   = 8'd255;
            m_far_n = 25'd0;
        end
    end

    // close path: exponents differ by at most one
    assign ms_c    = (ediff == 8'd0) ? {ms_sup, 1'b0} : {1'b0, ms_sup};
    assign mb_c    = {1'b0, mb_sup, 1'b0};
    assign d_bs    = mb_c - {1'b0, ms_c};
    assign d_sb    = {1'b0, ms_c} - mb_c;
    assign m_abs   = d_bs[25] ? d_sb[24:0] : d_bs[24:0];
    // exact cancellation gives +0
    assign s_close = (m_abs == 25'd0) ? 1'b0 : (s_big ^ d_bs[25]);

    lzc u_lzc (
        .x   (m_abs),
        .res (lz)
    );

    assign e_norm  = {1'b0, eb} - {4'd0, lz};
    assign udf_c   = e_norm[8] | (e_norm == 9'd0) | (m_abs == 25'd0);
    assign m_close = udf_c ? 25'd0 : m_abs << lz;
    assign e_close = udf_c ? 8'd0 : e_norm[7:0];

    // m_pre is hidden bit, 23 fraction bits, guard bit
    assign s_pre  = is_close ? s_close : s_far;
    assign e_pre  = is_close ? e_close : e_far;
    assign m_pre  = is_close ? m_close : m_far_n;
    assign st_pre = is_close ? 1'b0 : st_far;

    // nearest even
    assign round_up = m_pre[0] & (st_pre | m_pre[1]);
    assign m_rnd    = {1'b0, m_pre[24:1]} + {24'd0, round_up};

    // carry out of the mantissa bumps the exponent
    assign res = {s_pre,
                  m_rnd[24] ? e_pre + 8'd1 : e_pre,
                  m_rnd[24] ? 23'd0 : m_rnd[22:0]};

endmodule

// ==== src/fpu_decode.sv ====
`timescale 1ns/100ps

module fpu_decode (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  fpu_pkg::op_t    op,
    input  fpu_pkg::float_t x,
    input  fpu_pkg::float_t y,
    output logic            d_valid,
    output logic            d_is_cmp,
    output fpu_pkg::cmp_t   d_cmp,
    output fpu_pkg::float_t d_x,
    output fpu_pkg::float_t d_y
);

    logic          is_cmp;
    fpu_pkg::cmp_t cmp;
    logic          flip;

    // opcode to class and compare kind
    always_comb begin
        is_cmp = 1'b0;
        cmp    = fpu_pkg::CMP_EQ;
        flip   = 1'b0;
        case (op)
            fpu_pkg::OP_FADD: flip = 1'b0;
            fpu_pkg::OP_FSUB: flip = 1'b1;
            fpu_pkg::OP_FEQ: begin
                is_cmp = 1'b1;
                cmp    = fpu_pkg::CMP_EQ;
            end
            fpu_pkg::OP_FLT: begin
                is_cmp = 1'b1;
                cmp    = fpu_pkg::CMP_LT;
            end
            fpu_pkg::OP_FLE: begin
                is_cmp = 1'b1;
                cmp    = fpu_pkg::CMP_LE;
            end
            default: flip = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid  <= 1'b0;
            d_is_cmp <= 1'b0;
            d_cmp    <= fpu_pkg::CMP_EQ;
        end else begin
            d_valid <= in_valid;
            if (in_valid) begin
                d_is_cmp <= is_cmp;
                d_cmp    <= cmp;
            end
        end
    end

    // fsub becomes an add with y negated
    always_ff @(posedge clk) begin
        if (in_valid) begin
            d_x <= x;
            d_y <= {y[31] ^ flip, y[30:0]};
        end
    end

endmodule

// ==== src/fpu_result.sv ====
`timescale 1ns/100ps

module fpu_result (
    input  logic            clk,
    input  logic            rst,
    input  logic            d_valid,
    input  logic            d_is_cmp,
    input  fpu_pkg::cmp_t   d_cmp,
    input  fpu_pkg::float_t d_x,
    input  fpu_pkg::float_t d_y,
    input  fpu_pkg::float_t sum,
    output logic            out_valid,
    output logic            out_is_flag,
    output fpu_pkg::float_t out_float,
    output logic            out_flag
);

    fpu_pkg::exp_t ex;
    fpu_pkg::exp_t ey;
    logic          zx;
    logic          zy;
    logic          sx;
    logic          sy;
    logic [30:0]   mag_x;
    logic [30:0]   mag_y;
    logic          eq;
    logic          lt;
    logic          flag;

    assign ex = d_x[30:23];
    assign ey = d_y[30:23];
    assign zx = (ex == 8'd0);
    assign zy = (ey == 8'd0);

    // zeros lose their sign, so +0 equals -0
    assign sx    = d_x[31] & ~zx;
    assign sy    = d_y[31] & ~zy;
    assign mag_x = zx ? 31'd0 : d_x[30:0];
    assign mag_y = zy ? 31'd0 : d_y[30:0];

    assign eq = (sx == sy) & (mag_x == mag_y);

    // sign-magnitude order
    always_comb begin
        if (sx != sy) begin
            lt = sx;
        end else if (sx) begin
            lt = mag_x > mag_y;
        end else begin
            lt = mag_x < mag_y;
        end
    end

    always_comb begin
        case (d_cmp)
            fpu_pkg::CMP_EQ: flag = eq;
            fpu_pkg::CMP_LT: flag = lt;
            fpu_pkg::CMP_LE: flag = lt | eq;
            default:         flag = eq;
        endcase
    end

    // outputs hold between results
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_is_flag <= 1'b0;
            out_float   <= 32'd0;
            out_flag    <= 1'b0;
        end else begin
            out_valid <= d_valid;
            if (d_valid) begin
                out_is_flag <= d_is_cmp;
                if (d_is_cmp) begin
                    out_flag <= flag;
                end else begin
                    out_float <= sum;
                end
            end
        end
    end

endmodule

// ==== src/fpu_top.sv ====
`timescale 1ns/100ps

module fpu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  fpu_pkg::op_t    op,
    input  fpu_pkg::float_t x,
    input  fpu_pkg::float_t y,
    output logic            out_valid,
    output logic            out_is_flag,
    output fpu_pkg::float_t out_float,
    output logic            out_flag
);

    logic            d_valid;
    logic            d_is_cmp;
    fpu_pkg::cmp_t   d_cmp;
    fpu_pkg::float_t d_x;
    fpu_pkg::float_t d_y;
    fpu_pkg::float_t sum;

    fpu_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .op       (op),
        .x        (x),
        .y        (y),
        .d_valid  (d_valid),
        .d_is_cmp (d_is_cmp),
        .d_cmp    (d_cmp),
        .d_x      (d_x),
        .d_y      (d_y)
    );

    // adder sits between the two register stages
    fadd u_fadd (
        .x   (d_x),
        .y   (d_y),
        .res (sum)
    );

    fpu_result u_result (
        .clk         (clk),
        .rst         (rst),
        .d_valid     (d_valid),
        .d_is_cmp    (d_is_cmp),
        .d_cmp       (d_cmp),
        .d_x         (d_x),
        .d_y         (d_y),
        .sum         (sum),
        .out_valid   (out_valid),
        .out_is_flag (out_is_flag),
        .out_float   (out_float),
        .out_flag    (out_flag)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // two rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== bench/tb_fpu.sv ====
`timescale 1ns/100ps

module tb_fpu;

    localparam int NUM_OPS = 136;
    // spaced tests issue one operation every four cycles
    localparam int TIMEOUT_NS = (NUM_OPS * 4 + 100) * 40;

    logic            clk;
    logic            rst;
    logic            in_valid;
    fpu_pkg::op_t    op;
    fpu_pkg::float_t x;
    fpu_pkg::float_t y;
    logic            out_valid;
    logic            out_is_flag;
    fpu_pkg::float_t out_float;
    logic            out_flag;

    // pending operations and their expected results
    fpu_pkg::op_t    op_q[$];
    fpu_pkg::float_t x_q[$];
    fpu_pkg::float_t y_q[$];
    fpu_pkg::float_t float_q[$];
    logic            flag_q[$];
    logic            is_flag_q[$];
    logic [31:0]     seed = 32'h587f_85ce;
    int              errors = 0;
    int              checked = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    fpu_top uut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .op          (op),
        .x           (x),
        .y           (y),
        .out_valid   (out_valid),
        .out_is_flag (out_is_flag),
        .out_float   (out_float),
        .out_flag    (out_flag)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // uniform over -2^20 .. 2^20-1
    function automatic int rand_int();
        seed = xorshift(seed);
        return int'(seed[20:0]) - 1048576;
    endfunction

    // exact for magnitudes below 2^24
    function automatic fpu_pkg::float_t int_to_float(input int v);
        logic [31:0] mag;
        int          top;
        mag = (v < 0) ? -v : v;
        top = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag[i]) begin
                top = i;
            end
        end
        if (mag == 32'd0) begin
            return '0;
        end
        // hidden bit drops out of the 23-bit field
        return {v < 0, 8'(127 + top), 23'(mag << (23 - top))};
    endfunction

    task automatic push_op(input fpu_pkg::op_t o, input fpu_pkg::float_t xv,
                           input fpu_pkg::float_t yv, input fpu_pkg::float_t ef,
                           input logic eg);
        op_q.push_back(o);
        x_q.push_back(xv);
        y_q.push_back(yv);
        float_q.push_back(ef);
        flag_q.push_back(eg);
        is_flag_q.push_back(o == fpu_pkg::OP_FEQ || o == fpu_pkg::OP_FLT ||
                            o == fpu_pkg::OP_FLE);
    endtask

    task automatic push_int_op(input fpu_pkg::op_t o, input int a, input int b);
        fpu_pkg::float_t ef;
        logic            eg;
        ef = int_to_float(o == fpu_pkg::OP_FSUB ? a - b : a + b);
        case (o)
            fpu_pkg::OP_FEQ: eg = (a == b);
            fpu_pkg::OP_FLT: eg = (a < b);
            fpu_pkg::OP_FLE: eg = (a <= b);
            default:         eg = 1'b0;
        endcase
        push_op(o, int_to_float(a), int_to_float(b), ef, eg);
    endtask

    task automatic check_float(input string name, input fpu_pkg::float_t expected,
                               input fpu_pkg::float_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, got %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_result(input string name, input int k);
        checked++;
        if (out_valid !== 1'b1) begin
            $display("%s: out_valid did not rise for operation %0d", name, k);
            errors++;
        end else if (out_is_flag !== is_flag_q[k]) begin
            $display("%s: operation %0d came back with the wrong out_is_flag", name, k);
            errors++;
        end else if (is_flag_q[k]) begin
            check_flag(name, flag_q[k], out_flag);
        end else begin
            check_float(name, float_q[k], out_float);
        end
    endtask

    // issues the queued operations every gap+1 cycles and checks each 2 negedges later
    task automatic run_batch(input string name, input int gap);
        int c;
        int next;
        int k;
        int due_q[$];
        int idx_q[$];
        c = 0;
        next = 0;
        while (next < op_q.size() || idx_q.size() > 0) begin
            @(negedge clk);
            if (idx_q.size() > 0 && due_q[0] == c) begin
                k = idx_q.pop_front();
                void'(due_q.pop_front());
                check_result(name, k);
            end else if (out_valid !== 1'b0) begin
                $display("%s: out_valid was high with no result due", name);
                errors++;
            end
            if (next < op_q.size() && c % (gap + 1) == 0) begin
                in_valid = 1'b1;
                op = op_q[next];
                x = x_q[next];
                y = y_q[next];
                idx_q.push_back(next);
                due_q.push_back(c + 2);
                next++;
            end else begin
                in_valid = 1'b0;
            end
            c++;
        end
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("%s: out_valid stayed high after the last result", name);
            errors++;
        end
        op_q.delete();
        x_q.delete();
        y_q.delete();
        float_q.delete();
        flag_q.delete();
        is_flag_q.delete();
    endtask

    task automatic test_int_add_sub();
        int a;
        int b;
        for (int i = 0; i < 40; i++) begin
            a = rand_int();
            b = rand_int();
            // some pairs cancel to +0 in fsub
            if (i % 4 == 0) begin
                b = a;
            end
            push_int_op(fpu_pkg::OP_FADD, a, b);
            push_int_op(fpu_pkg::OP_FSUB, a, b);
        end
        run_batch("int_add_sub", 3);
    endtask

    task automatic test_round_even();
        // tie with the lsb already even
        push_op(fpu_pkg::OP_FADD, 32'h3f80_0000, 32'h3380_0000, 32'h3f80_0000, 1'b0);
        // tie with an odd lsb rounds up
        push_op(fpu_pkg::OP_FADD, 32'h3f80_0001, 32'h3380_0000, 32'h3f80_0002, 1'b0);
        // 3 * 2^-25 is above half an ulp
        push_op(fpu_pkg::OP_FADD, 32'h3f80_0000, 32'h33c0_0000, 32'h3f80_0001, 1'b0);
        run_batch("round_even", 3);
    endtask

    task automatic test_zero_overflow();
        push_op(fpu_pkg::OP_FADD, 32'h0000_0001, 32'h0000_0000, 32'h0000_0000, 1'b0);
        push_op(fpu_pkg::OP_FADD, 32'h4049_0fdb, 32'hc049_0fdb, 32'h0000_0000, 1'b0);
        // largest finite doubled with both signs
        push_op(fpu_pkg::OP_FADD, 32'h7f7f_ffff, 32'h7f7f_ffff, 32'h7f80_0000, 1'b0);
        push_op(fpu_pkg::OP_FADD, 32'hff7f_ffff, 32'hff7f_ffff, 32'hff80_0000, 1'b0);
        run_batch("zero_overflow", 3);
    endtask

    task automatic test_compare();
        int a;
        int b;
        for (int i = 0; i < 12; i++) begin
            a = rand_int();
            b = rand_int();
            if (i >= 10) begin
                a = (a < 0) ? -a : a;
                b = (b < 0) ? b : -b - 1;
            end else if (i >= 8) begin
                b = a;
            end
            push_int_op(fpu_pkg::OP_FEQ, a, b);
            push_int_op(fpu_pkg::OP_FLT, a, b);
            push_int_op(fpu_pkg::OP_FLE, a, b);
        end
        // +0 against -0
        push_op(fpu_pkg::OP_FEQ, 32'h0000_0000, 32'h8000_0000, 32'h0, 1'b1);
        push_op(fpu_pkg::OP_FLT, 32'h0000_0000, 32'h8000_0000, 32'h0, 1'b0);
        push_op(fpu_pkg::OP_FLE, 32'h0000_0000, 32'h8000_0000, 32'h0, 1'b1);
        run_batch("compare", 3);
    endtask

    task automatic test_pipeline();
        int a;
        int b;
        for (int i = 0; i < 10; i++) begin
            a = rand_int();
            b = rand_int();
            push_int_op(fpu_pkg::op_t'(i % 5), a, b);
        end
        run_batch("pipeline", 0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        in_valid = 1'b0;
        op = fpu_pkg::OP_FADD;
        x = '0;
        y = '0;
        wait (rst == 1'b1);
        wait (rst == 1'b0);
        test_int_add_sub();
        test_round_even();
        test_zero_overflow();
        test_compare();
        test_pipeline();
        $display("operations checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== fpu.f ====
src/fpu_pkg.sv
src/lzc.sv
src/fadd.sv
src/fpu_decode.sv
src/fpu_result.sv
src/fpu_top.sv
bench/tb_clock.sv
bench/tb_fpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fpu testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fpu -Mdir obj_dir -f fpu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
